// ==== src/core_pkg.sv ====
package core_pkg;

    // ************************************************************
    // datapath width
    // ************************************************************
    localparam int XLEN = 64;

    // ************************************************************
    // major opcodes handled by the decoder
    // ************************************************************
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // alu operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_e;

    // ************************************************************
    // machine mode csr addresses
    // ************************************************************
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // environment call from m-mode
    localparam logic [XLEN-1:0] MCAUSE_ECALL_M = 64'd11;

endpackage

// ==== src/rv64_fetch.sv ====
`timescale 1ns/1ns

module rv64_fetch import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [31:0]     imem_inst_i,
    output logic [XLEN-1:0] pc_id_o,
    output logic [31:0]     inst_id_o,
    output logic            valid_id_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    // memory answers in the same cycle
    assign imem_addr_o = pc_q;

    // jump target from decode wins over the sequential pc
    assign pc_next = redirect_i ? redirect_pc_i : pc_q + 64'd4;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // ************************************************************
    // if/id register
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            valid_id_o <= 1'b0;
        end else begin
            // word fetched under a redirect is on the wrong path
            valid_id_o <= ~redirect_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_id_o   <= pc_q;
        inst_id_o <= imem_inst_i;
    end

endmodule

// ==== src/rv64_decode.sv ====
`timescale 1ns/1ns

module rv64_decode import core_pkg::*; (
    input  logic [XLEN-1:0] pc_i,
    input  logic [31:0]     inst_i,
    input  logic            valid_i,
    input  logic [XLEN-1:0] rdata1_i,
    input  logic [XLEN-1:0] rdata2_i,
    input  logic [XLEN-1:0] csr_rdata_i,
    input  logic [XLEN-1:0] mtvec_i,
    output logic [4:0]      raddr1_o,
    output logic [4:0]      raddr2_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic            csr_we_o,
    output logic [11:0]     csr_addr_o,
    output logic [XLEN-1:0] csr_wdata_o,
    output logic            ecall_o,
    output logic            ex_valid_o,
    output alu_op_e         alu_op_o,
    output logic [XLEN-1:0] op1_o,
    output logic [XLEN-1:0] op2_o,
    output logic [4:0]      rd_o,
    output logic            reg_we_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            inst_ok;
    logic            is_jal;
    logic            is_ecall;
    logic            is_csrrw;

    // ************************************************************
    // fields and immediates
    // ************************************************************
    assign opcode   = opcode_e'(inst_i[6:0]);
    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];
    assign rd_o     = inst_i[11:7];
    assign raddr1_o = inst_i[19:15];
    assign raddr2_o = inst_i[24:20];

    assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // ************************************************************
    // operands and alu op per instruction
    // ************************************************************
    always_comb begin
        inst_ok  = 1'b0;
        reg_we_o = 1'b0;
        is_jal   = 1'b0;
        is_ecall = 1'b0;
        is_csrrw = 1'b0;
        alu_op_o = ALU_ADD;
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
        case (opcode)
            OPC_OP_IMM: begin
                op2_o    = imm_i;
                reg_we_o = 1'b1;
                inst_ok  = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    // rv64 slli keeps a 6 bit shamt
                    3'b001: begin
                        inst_ok  = (inst_i[31:26] == 6'b0);
                        alu_op_o = ALU_SLL;
                    end
                    default: inst_ok = 1'b0;
                endcase
            end
            OPC_OP: begin
                reg_we_o = 1'b1;
                inst_ok  = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op_o = ALU_ADD;
                    10'b0100000_000: alu_op_o = ALU_SUB;
                    10'b0000000_001: alu_op_o = ALU_SLL;
                    10'b0000000_100: alu_op_o = ALU_XOR;
                    10'b0000000_110: alu_op_o = ALU_OR;
                    10'b0000000_111: alu_op_o = ALU_AND;
                    default:         inst_ok  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                inst_ok  = 1'b1;
                reg_we_o = 1'b1;
                op1_o    = '0;
                op2_o    = imm_u;
            end
            OPC_JAL: begin
                // link value pc + 4
                inst_ok  = 1'b1;
                reg_we_o = 1'b1;
                is_jal   = 1'b1;
                op1_o    = pc_i;
                op2_o    = 64'd4;
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b001) begin
                    // old csr value goes to rd
                    inst_ok  = 1'b1;
                    reg_we_o = 1'b1;
                    is_csrrw = 1'b1;
                    op1_o    = csr_rdata_i;
                    op2_o    = '0;
                end else if (inst_i == 32'h0000_0073) begin
                    inst_ok  = 1'b1;
                    is_ecall = 1'b1;
                end
            end
            default: inst_ok = 1'b0;
        endcase
    end

    assign ex_valid_o = valid_i & inst_ok;

    // jump decision
    assign redirect_o    = valid_i & (is_jal | is_ecall);
    assign redirect_pc_o = is_ecall ? mtvec_i : pc_i + imm_j;

    // csr controls
    assign csr_we_o    = valid_i & is_csrrw;
    assign csr_addr_o  = inst_i[31:20];
    assign csr_wdata_o = rdata1_i;
    assign ecall_o     = valid_i & is_ecall;

endmodule

// ==== src/rv64_csr.sv ====
`timescale 1ns/1ns

module rv64_csr import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] pc_i,
    input  logic            csr_we_i,
    input  logic [11:0]     csr_addr_i,
    input  logic [XLEN-1:0] csr_wdata_i,
    input  logic            ecall_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic [XLEN-1:0] mtvec_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    // ************************************************************
    // read port, old value seen in the same cycle
    // ************************************************************
    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS: csr_rdata_o = mstatus_q;
            CSR_MTVEC:   csr_rdata_o = mtvec_q;
            CSR_MEPC:    csr_rdata_o = mepc_q;
            CSR_MCAUSE:  csr_rdata_o = mcause_q;
            // unimplemented csrs
            default:     csr_rdata_o = '0;
        endcase
    end

    assign mtvec_o = mtvec_q;

    // ************************************************************
    // csrrw write and ecall update
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (ecall_i) begin
            // trap entry, m-mode only
            mepc_q   <= pc_i;
            mcause_q <= MCAUSE_ECALL_M;
        end else if (csr_we_i) begin
            case (csr_addr_i)
                CSR_MSTATUS: mstatus_q <= csr_wdata_i;
                CSR_MTVEC:   mtvec_q   <= csr_wdata_i;
                CSR_MEPC:    mepc_q    <= csr_wdata_i;
                CSR_MCAUSE:  mcause_q  <= csr_wdata_i;
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== src/rv64_execute.sv ====
`timescale 1ns/1ns

module rv64_execute import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_i,
    input  alu_op_e         alu_op_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  logic [4:0]      rd_i,
    input  logic            reg_we_i,
    output logic            wb_en_o,
    output logic [4:0]      wb_addr_o,
    output logic [XLEN-1:0] wb_data_o
);

    logic            valid_q;
    alu_op_e         alu_op_q;
    logic [XLEN-1:0] op1_q;
    logic [XLEN-1:0] op2_q;
    logic [4:0]      rd_q;
    logic            reg_we_q;
    logic [XLEN-1:0] alu_res;

    // ************************************************************
    // id/ex register
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_op_q <= alu_op_i;
        op1_q    <= op1_i;
        op2_q    <= op2_i;
        rd_q     <= rd_i;
        reg_we_q <= reg_we_i;
    end

    // ************************************************************
    // alu
    // ************************************************************
    always_comb begin
        case (alu_op_q)
            ALU_ADD: alu_res = op1_q + op2_q;
            ALU_SUB: alu_res = op1_q - op2_q;
            ALU_AND: alu_res = op1_q & op2_q;
            ALU_OR:  alu_res = op1_q | op2_q;
            ALU_XOR: alu_res = op1_q ^ op2_q;
            // shift amount from low 6 bits
            ALU_SLL: alu_res = op1_q << op2_q[5:0];
            default: alu_res = '0;
        endcase
    end

    // write-back port, x0 never written
    assign wb_en_o   = valid_q & reg_we_q & (rd_q != 5'd0);
    assign wb_addr_o = rd_q;
    assign wb_data_o = alu_res;

endmodule

// ==== src/rv64_regfile.sv ====
`timescale 1ns/1ns

module rv64_regfile import core_pkg::*; (
    input  logic            clk,
    input  logic [4:0]      raddr1_i,
    input  logic [4:0]      raddr2_i,
    output logic [XLEN-1:0] rdata1_o,
    output logic [XLEN-1:0] rdata2_o,
    input  logic            we_i,
    input  logic [4:0]      waddr_i,
    input  logic [XLEN-1:0] wdata_i
);

    logic [XLEN-1:0] regs [32];

    // x0 reads zero, same-cycle write is forwarded
    function automatic logic [XLEN-1:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (we_i && (waddr_i == addr)) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    assign rdata1_o = read_reg(raddr1_i);
    assign rdata2_o = read_reg(raddr2_i);

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

// ==== src/rv64_core.sv ====
`timescale 1ns/1ns

module rv64_core import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [31:0]     imem_inst_i,
    output logic [XLEN-1:0] pc_id_o,
    output logic [31:0]     inst_id_o,
    output logic            wb_en_o,
    output logic [4:0]      wb_addr_o,
    output logic [XLEN-1:0] wb_data_o
);

    // fetch <-> decode
    logic            valid_id;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    // register file reads
    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;

    // csr unit
    logic            csr_we;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_wdata;
    logic            ecall;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] mtvec;

    // decode -> execute
    logic            ex_valid;
    alu_op_e         alu_op;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      rd;
    logic            reg_we;

    // ************************************************************
    // stage 1, fetch and if/id
    // ************************************************************
    rv64_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_inst_i   (imem_inst_i),
        .pc_id_o       (pc_id_o),
        .inst_id_o     (inst_id_o),
        .valid_id_o    (valid_id)
    );

    // ************************************************************
    // stage 2, decode with csr unit
    // ************************************************************
    rv64_decode u_decode (
        .pc_i          (pc_id_o),
        .inst_i        (inst_id_o),
        .valid_i       (valid_id),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .csr_rdata_i   (csr_rdata),
        .mtvec_i       (mtvec),
        .raddr1_o      (raddr1),
        .raddr2_o      (raddr2),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .csr_we_o      (csr_we),
        .csr_addr_o    (csr_addr),
        .csr_wdata_o   (csr_wdata),
        .ecall_o       (ecall),
        .ex_valid_o    (ex_valid),
        .alu_op_o      (alu_op),
        .op1_o         (op1),
        .op2_o         (op2),
        .rd_o          (rd),
        .reg_we_o      (reg_we)
    );

    rv64_csr u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_i        (pc_id_o),
        .csr_we_i    (csr_we),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .ecall_i     (ecall),
        .csr_rdata_o (csr_rdata),
        .mtvec_o     (mtvec)
    );

    // ************************************************************
    // stage 3, execute and write-back
    // ************************************************************
    rv64_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (ex_valid),
        .alu_op_i  (alu_op),
        .op1_i     (op1),
        .op2_i     (op2),
        .rd_i      (rd),
        .reg_we_i  (reg_we),
        .wb_en_o   (wb_en_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

    rv64_regfile u_regfile (
        .clk      (clk),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_en_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

endmodule

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ************************************************************
// galois lfsr random source
// ************************************************************
logic [31:0] lfsr_state = 32'h7d24_9cac;

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return r;
endfunction

// ************************************************************
// instruction encoders
// ************************************************************
function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

// byte offset with bit 0 dropped
function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] enc_csrrw(input logic [4:0] rd, input logic [11:0] csr,
                                          input logic [4:0] rs1);
    return {csr, rs1, 3'b001, rd, 7'b1110011};
endfunction

localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

// ************************************************************
// in-order reference state and expected results
// ************************************************************
logic [63:0] mregs [32];
logic [63:0] m_mstatus;
logic [63:0] m_mtvec;
logic [63:0] m_mepc;
logic [63:0] m_mcause;
logic [4:0]  exp_addr [$];
logic [63:0] exp_data [$];
logic [63:0] exp_redir_from [$];
logic [63:0] exp_redir_to [$];

function automatic logic [63:0] model_csr_read(input logic [11:0] a);
    case (a)
        12'h300: return m_mstatus;
        12'h305: return m_mtvec;
        12'h341: return m_mepc;
        12'h342: return m_mcause;
        default: return 64'd0;
    endcase
endfunction

task automatic model_csr_write(input logic [11:0] a, input logic [63:0] v);
    case (a)
        12'h300: m_mstatus = v;
        12'h305: m_mtvec = v;
        12'h341: m_mepc = v;
        12'h342: m_mcause = v;
        default: begin
        end
    endcase
endtask

// walks the loaded program from the reset pc until it leaves the program
task automatic model_run(input int len);
    logic [63:0] pc;
    logic [63:0] nxt;
    logic [63:0] res;
    logic [63:0] v1;
    logic [63:0] v2;
    logic [63:0] idx;
    logic [31:0] w;
    logic        wr;
    int          steps;
    m_mstatus = '0;
    m_mtvec   = '0;
    m_mepc    = '0;
    m_mcause  = '0;
    pc    = RESET_PC;
    steps = 0;
    idx   = '0;
    while ((idx < 64'(len)) && (steps < 1000)) begin
        w   = imem[idx[7:0]];
        v1  = mregs[w[19:15]];
        v2  = mregs[w[24:20]];
        nxt = pc + 64'd4;
        res = '0;
        wr  = 1'b0;
        case (w[6:0])
            7'b0010011: begin
                wr = 1'b1;
                case (w[14:12])
                    3'b000: res = v1 + {{52{w[31]}}, w[31:20]};
                    3'b100: res = v1 ^ {{52{w[31]}}, w[31:20]};
                    3'b110: res = v1 | {{52{w[31]}}, w[31:20]};
                    3'b111: res = v1 & {{52{w[31]}}, w[31:20]};
                    3'b001: begin
                        wr  = (w[31:26] == 6'd0);
                        res = v1 << w[25:20];
                    end
                    default: wr = 1'b0;
                endcase
            end
            7'b0110011: begin
                wr = 1'b1;
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: res = v1 + v2;
                    10'b0100000_000: res = v1 - v2;
                    10'b0000000_001: res = v1 << v2[5:0];
                    10'b0000000_100: res = v1 ^ v2;
                    10'b0000000_110: res = v1 | v2;
                    10'b0000000_111: res = v1 & v2;
                    default:         wr  = 1'b0;
                endcase
            end
            7'b0110111: begin
                wr  = 1'b1;
                res = {{32{w[31]}}, w[31:12], 12'd0};
            end
            7'b1101111: begin
                wr  = 1'b1;
                res = pc + 64'd4;
                nxt = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                exp_redir_from.push_back(pc);
                exp_redir_to.push_back(nxt);
            end
            7'b1110011: begin
                if (w[14:12] == 3'b001) begin
                    wr  = 1'b1;
                    res = model_csr_read(w[31:20]);
                    model_csr_write(w[31:20], v1);
                end else if (w == ECALL_WORD) begin
                    nxt      = m_mtvec;
                    m_mepc   = pc;
                    m_mcause = 64'd11;
                    exp_redir_from.push_back(pc);
                    exp_redir_to.push_back(nxt);
                end
            end
            default: begin
            end
        endcase
        if (wr && (w[11:7] != 5'd0)) begin
            mregs[w[11:7]] = res;
            exp_addr.push_back(w[11:7]);
            exp_data.push_back(res);
        end
        pc    = nxt;
        idx   = (pc - RESET_PC) >> 2;
        steps = steps + 1;
    end
endtask

`endif

// ==== test/tb_rv64_core.sv ====
`timescale 1ns/1ns

module tb_rv64_core import core_pkg::*;;

    localparam logic [63:0] RESET_PC = 64'h0000_0000_0000_1000;

    logic        clk;
    logic        rst_n;
    logic [63:0] imem_addr_o;
    logic [31:0] imem_inst_i;
    logic [63:0] pc_id_o;
    logic [31:0] inst_id_o;
    logic        wb_en_o;
    logic [4:0]  wb_addr_o;
    logic [63:0] wb_data_o;

    logic [31:0] imem [256];
    logic [31:0] prog [$];
    logic [63:0] imem_off;
    logic [63:0] redir_target;
    logic        redir_pending;
    logic [63:0] prev_fetch_addr;
    logic [31:0] prev_fetch_word;
    logic        prev_fetch_ok;
    int          fail_count;

    `include "tb_ref_model.svh"

    rv64_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr_o (imem_addr_o),
        .imem_inst_i (imem_inst_i),
        .pc_id_o     (pc_id_o),
        .inst_id_o   (inst_id_o),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

    always #10 clk = ~clk;

    // undecodable fill word folded from the whole address
    function automatic logic [31:0] fill_word(input logic [63:0] a);
        logic [31:0] f;
        f = a[63:32] ^ a[31:0];
        return {f[31:7] ^ f[24:0], 7'b0000000};
    endfunction

    // memory answers in the same cycle
    assign imem_off    = imem_addr_o - RESET_PC;
    assign imem_inst_i = (imem_off[63:10] == '0) ? imem[imem_off[9:2]] : fill_word(imem_addr_o);

    task automatic report_mismatch(input string msg);
        fail_count++;
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic report_failure(input string msg);
        fail_count++;
        $display("error at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    // ************************************************************
    // commit and redirect checking
    // ************************************************************
    always @(negedge clk) begin
        if (rst_n === 1'b0 && wb_en_o === 1'b1) begin
            assert (exp_addr.size() > 0)
                else report_failure("the core wrote a register when no write was expected");
            assert (wb_addr_o == exp_addr[0] && wb_data_o == exp_data[0])
                else report_mismatch($sformatf("commit x%0d = %h, expected x%0d = %h",
                                     wb_addr_o, wb_data_o, exp_addr[0], exp_data[0]));
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
    end

    always @(negedge clk) begin
        if (rst_n === 1'b0) begin
            if (redir_pending) begin
                assert (imem_addr_o == redir_target)
                    else report_mismatch($sformatf("fetch address %h after jump, expected %h",
                                         imem_addr_o, redir_target));
                redir_pending = 1'b0;
            end
            if (exp_redir_from.size() > 0 && pc_id_o == exp_redir_from[0] &&
                (inst_id_o[6:0] == OPC_JAL || inst_id_o[6:0] == OPC_SYSTEM)) begin
                redir_target  = exp_redir_to[0];
                redir_pending = 1'b1;
                void'(exp_redir_from.pop_front());
                void'(exp_redir_to.pop_front());
            end
        end
    end

    // if/id holds the address and word fetched one cycle earlier
    always @(negedge clk) begin
        if (rst_n === 1'b0 && prev_fetch_ok) begin
            assert (pc_id_o == prev_fetch_addr && inst_id_o == prev_fetch_word)
                else report_mismatch($sformatf("if/id holds %h at %h, expected %h at %h",
                                     inst_id_o, pc_id_o, prev_fetch_word, prev_fetch_addr));
        end
        prev_fetch_ok   = (rst_n === 1'b0);
        prev_fetch_addr = imem_addr_o;
        prev_fetch_word = imem_inst_i;
    end

    // reset, load, model, release and wait for all expected results
    task automatic run_program(input bit check_fetch);
        int len;
        int cyc;
        len = prog.size();
        @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(RESET_PC + 64'(i) * 64'd4);
        end
        for (int i = 0; i < len; i++) begin
            imem[i] = prog[i];
        end
        model_run(len);
        repeat (5) @(posedge clk);
        rst_n <= 1'b0;
        cyc = 0;
        while (exp_addr.size() > 0 || exp_redir_to.size() > 0 || redir_pending ||
               cyc < len + 4) begin
            @(negedge clk);
            if (cyc < 2) begin
                assert (wb_en_o === 1'b0)
                    else report_mismatch($sformatf("write-back active in cycle %0d", cyc));
            end
            if (check_fetch && cyc < len) begin
                assert (imem_addr_o == RESET_PC + 64'(cyc) * 64'd4)
                    else report_mismatch($sformatf("fetch address %h in cycle %0d",
                                         imem_addr_o, cyc));
            end
            cyc++;
            if (cyc > 400) begin
                report_failure("the program did not finish its expected writes in time");
            end
        end
        prog.delete();
    endtask

    // ************************************************************
    // programs
    // ************************************************************
    task automatic gen_random(input int n, input bit chain);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev;
        int          kind;
        prev = 5'd1;
        for (int i = 0; i < n; i++) begin
            kind = int'(rand_bits(4) % 32'd12);
            r    = rand_bits(3);
            rd   = r[4:0];
            r    = rand_bits(3);
            rs1  = r[4:0];
            r    = rand_bits(3);
            rs2  = r[4:0];
            if (chain) begin
                rs1  = prev;
                rd   = (rd == 5'd0) ? 5'd1 : rd;
                prev = rd;
            end
            r = rand_bits(20);
            case (kind)
                0:  prog.push_back(enc_lui(rd, r[19:0]));
                1:  prog.push_back(enc_i(3'b000, rd, rs1, r[11:0]));
                2:  prog.push_back(enc_i(3'b111, rd, rs1, r[11:0]));
                3:  prog.push_back(enc_i(3'b110, rd, rs1, r[11:0]));
                4:  prog.push_back(enc_i(3'b100, rd, rs1, r[11:0]));
                5:  prog.push_back(enc_i(3'b001, rd, rs1, {6'd0, r[5:0]}));
                6:  prog.push_back(enc_r(7'h00, 3'b000, rd, rs1, rs2));
                7:  prog.push_back(enc_r(7'h20, 3'b000, rd, rs1, rs2));
                8:  prog.push_back(enc_r(7'h00, 3'b111, rd, rs1, rs2));
                9:  prog.push_back(enc_r(7'h00, 3'b110, rd, rs1, rs2));
                10: prog.push_back(enc_r(7'h00, 3'b100, rd, rs1, rs2));
                default: prog.push_back(enc_r(7'h00, 3'b001, rd, rs1, rs2));
            endcase
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b1;
        fail_count    = 0;
        redir_pending = 1'b0;
        redir_target  = '0;
        prev_fetch_ok = 1'b0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end

        // sequential fetch that also sets x1..x7
        for (int i = 1; i < 8; i++) begin
            prog.push_back(enc_i(3'b000, 5'(i), 5'd0, 12'(i * 291)));
        end
        prog.push_back(enc_i(3'b000, 5'd0, 5'd1, 12'h7ff));
        run_program(1'b1);

        gen_random(60, 1'b0);
        run_program(1'b0);
        gen_random(30, 1'b1);
        run_program(1'b0);

        // jal over two words
        prog.push_back(enc_i(3'b000, 5'd1, 5'd0, 12'h05a));
        prog.push_back(enc_jal(5'd5, 21'd12));
        prog.push_back(enc_i(3'b000, 5'd6, 5'd0, 12'h111));
        prog.push_back(enc_i(3'b000, 5'd7, 5'd0, 12'h222));
        prog.push_back(enc_i(3'b000, 5'd2, 5'd5, 12'h001));
        run_program(1'b0);

        // csrrw on mtvec and an unimplemented csr, then ecall to the handler at word 16
        prog.push_back(enc_lui(5'd1, 20'h00001));
        prog.push_back(enc_i(3'b000, 5'd1, 5'd1, 12'h040));
        prog.push_back(enc_csrrw(5'd2, CSR_MTVEC, 5'd1));
        prog.push_back(enc_csrrw(5'd3, CSR_MTVEC, 5'd1));
        prog.push_back(enc_csrrw(5'd4, 12'h7c0, 5'd1));
        prog.push_back(ECALL_WORD);
        for (int i = 6; i < 16; i++) begin
            prog.push_back(enc_i(3'b000, 5'd5, 5'd0, 12'(i)));
        end
        prog.push_back(enc_csrrw(5'd6, CSR_MEPC, 5'd0));
        prog.push_back(enc_csrrw(5'd7, CSR_MCAUSE, 5'd0));
        prog.push_back(enc_csrrw(5'd8, CSR_MSTATUS, 5'd0));
        run_program(1'b0);

        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "errors were found");
        end
    end

endmodule

// ==== rv64_core.f ====
+incdir+test
src/core_pkg.sv
src/rv64_fetch.sv
src/rv64_decode.sv
src/rv64_csr.sv
src/rv64_execute.sv
src/rv64_regfile.sv
src/rv64_core.sv
test/tb_rv64_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv64_core testbench with verilator

LOG=sim.log

if ! verilator --binary --timing --top-module tb_rv64_core -f rv64_core.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv64_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0
